/* src/link_pkg.sv */
// Shared widths, frame buffer address constants and packed link structs
package link_pkg;

  // ====================
  // Widths with a meaning
  // ====================

  // One UART data byte
  typedef logic [7:0] byte_t;

  // Frame buffer word address
  typedef logic [22:0] addr_t;

  // Stored image index as sent over the UART
  typedef logic [7:0] img_idx_t;

  // ====================
  // Link beats
  // ====================

  // Received byte, also used for the store output
  typedef struct packed {
    logic  valid;
    byte_t data;
  } rx_beat_t;

  // Transmit request, start is a one-cycle strobe
  typedef struct packed {
    logic  start;
    byte_t data;
  } tx_req_t;

  // Thumbnail send sequencer states
  typedef enum logic [1:0] {IDLE, FETCH, LOAD, SEND} send_state_t;

  // ====================
  // Frame buffer layout
  // ====================

  // Words in one 640x480 frame
  localparam addr_t FRAME_WORDS = 23'd307200;
  localparam addr_t IMAGE_BASE  = 23'h050000;
  localparam addr_t LIVE_BASE   = 23'h000000;

endpackage

/* src/baud_timer.sv */
// Bit-period timer with a separate length for the first interval
module baud_timer #(
  parameter int CLKS_PER_BIT = 434,
  parameter int FIRST_CLKS   = 434
) (
  input  logic CLOCK_50,
  input  logic DLY_RST_0,
  input  logic run,
  output logic tick
);

  localparam int MAX_CLKS = (CLKS_PER_BIT > FIRST_CLKS) ? CLKS_PER_BIT : FIRST_CLKS;
  localparam int CNT_W    = (MAX_CLKS > 1) ? $clog2(MAX_CLKS) : 1;

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] last;
  logic             first;

  // Terminal count depends on whether this is the first interval
  assign last = first ? CNT_W'(FIRST_CLKS - 1) : CNT_W'(CLKS_PER_BIT - 1);
  assign tick = (count == last);

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      count <= '0;
      first <= 1'b1;
    end else if (!run) begin
      count <= '0;
      first <= 1'b1;
    end else if (tick) begin
      count <= '0;
      first <= 1'b0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // Ticks only while the owner keeps the timer running
  a_no_idle_tick: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0)
    !run |-> !tick
  );

endmodule

/* src/uart_rx.sv */
// UART 8N1 receiver with input synchronizer, start-bit check and stop-bit check
module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic               CLOCK_50,
  input  logic               DLY_RST_0,
  input  logic               rx,
  output link_pkg::rx_beat_t rx_beat
);
  import link_pkg::*;

  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  logic       start_edge;
  logic       active;
  logic       tick;
  logic [3:0] bit_idx;
  byte_t      shift_q;

  // ====================
  // Line synchronizer
  // ====================

  // Line idles high, so the stages reset high
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev && !rx_sync;

  // First tick lands in the middle of the start bit
  baud_timer #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .FIRST_CLKS   (CLKS_PER_BIT / 2)
  ) u_timer (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .run       (active),
    .tick      (tick)
  );

  // ====================
  // Frame control
  // ====================

  // Bit 0 is the start bit, 1 to 8 are data, 9 is the stop bit
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      active  <= 1'b0;
      bit_idx <= '0;
    end else if (!active) begin
      bit_idx <= '0;
      if (start_edge) begin
        active <= 1'b1;
      end
    end else if (tick) begin
      bit_idx <= bit_idx + 4'd1;
      // Glitch on the line, not a real start bit
      if (bit_idx == 4'd0 && rx_sync) begin
        active <= 1'b0;
      end else if (bit_idx == 4'd9) begin
        active <= 1'b0;
      end
    end
  end

  // LSB arrives first
  always_ff @(posedge CLOCK_50) begin
    if (active && tick && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
  end

  // Framing error leaves valid low and the byte is lost
  assign rx_beat.valid = active && tick && (bit_idx == 4'd9) && rx_sync;
  assign rx_beat.data  = shift_q;

endmodule

/* src/uart_tx.sv */
// UART 8N1 transmitter driven by a start strobe, with a done strobe per frame
module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic              CLOCK_50,
  input  logic              DLY_RST_0,
  input  link_pkg::tx_req_t tx_req,
  output logic              tx,
  output logic              tx_done
);

  logic       active;
  logic       tick;
  logic       tx_q;
  logic [3:0] bit_idx;
  logic [8:0] shift_q;

  // Full bit period from the first cycle the line is low
  baud_timer #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .FIRST_CLKS   (CLKS_PER_BIT)
  ) u_timer (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .run       (active),
    .tick      (tick)
  );

  // ====================
  // Frame control
  // ====================

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      active  <= 1'b0;
      bit_idx <= '0;
      tx_q    <= 1'b1;
    end else if (!active) begin
      bit_idx <= '0;
      if (tx_req.start) begin
        active <= 1'b1;
        // Start bit goes out right away
        tx_q   <= 1'b0;
      end
    end else if (tick) begin
      if (bit_idx == 4'd9) begin
        active <= 1'b0;
        tx_q   <= 1'b1;
      end else begin
        bit_idx <= bit_idx + 4'd1;
        tx_q    <= shift_q[0];
      end
    end
  end

  // Data bits followed by the stop bit, shifted out LSB first
  always_ff @(posedge CLOCK_50) begin
    if (!active && tx_req.start) begin
      shift_q <= {1'b1, tx_req.data};
    end else if (active && tick) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign tx      = tx_q;
  assign tx_done = active && tick && (bit_idx == 4'd9);

  // Sequencer must wait for tx_done before the next start
  a_no_start_busy: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0)
    tx_req.start |-> !active
  );

endmodule

/* src/image_select.sv */
// Image index register, frame read base, store output and display restart detect
module image_select (
  input  logic               CLOCK_50,
  input  logic               DLY_RST_0,
  input  link_pkg::rx_beat_t rx_beat,
  input  logic               store_mode,
  input  logic               gray_mode,
  output link_pkg::addr_t    frame_base,
  output link_pkg::rx_beat_t store_beat,
  output logic               display_restart
);
  import link_pkg::*;

  img_idx_t img_q;
  addr_t    base_q;
  logic     store_valid_q;
  byte_t    store_data_q;
  img_idx_t img_prev;
  logic     gray_prev;
  logic     restart_q;

  // ====================
  // Byte routing
  // ====================

  // Store switch steals received bytes from the image index
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      img_q         <= '0;
      store_valid_q <= 1'b0;
    end else begin
      store_valid_q <= rx_beat.valid && store_mode;
      if (rx_beat.valid && !store_mode) begin
        img_q <= rx_beat.data;
      end
    end
  end

  always_ff @(posedge CLOCK_50) begin
    store_data_q <= rx_beat.data;
  end

  assign store_beat = '{valid: store_valid_q, data: store_data_q};

  // Gray mode shows the live camera frame, else one stored frame per index
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      base_q <= IMAGE_BASE;
    end else begin
      base_q <= gray_mode ? LIVE_BASE : IMAGE_BASE + FRAME_WORDS * addr_t'(img_q);
    end
  end

  assign frame_base = base_q;

  // ====================
  // Restart detect
  // ====================

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      img_prev  <= '0;
      gray_prev <= 1'b0;
      restart_q <= 1'b0;
    end else begin
      img_prev  <= img_q;
      gray_prev <= gray_mode;
      restart_q <= (img_q != img_prev) || (gray_mode != gray_prev);
    end
  end

  assign display_restart = restart_q;

  // A stored byte never moves the displayed image
  a_store_no_index: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0)
    store_beat.valid |-> $stable(img_q)
  );

endmodule

/* src/send_fsm.sv */
// Thumbnail send sequencer with byte counter and transmit request register
module send_fsm #(
  parameter int THUMB_BYTES = 1024
) (
  input  logic              CLOCK_50,
  input  logic              DLY_RST_0,
  input  logic              send_req,
  input  logic              abort,
  input  link_pkg::byte_t   thumb_data,
  output logic              thumb_rd,
  output link_pkg::tx_req_t tx_req,
  input  logic              tx_done,
  output logic              busy
);
  import link_pkg::*;

  localparam int CNT_W = $clog2(THUMB_BYTES + 1);

  send_state_t      state;
  send_state_t      state_next;
  logic [CNT_W-1:0] byte_cnt;
  logic             last_byte;
  logic             issue;
  logic             tx_pending;
  logic             tx_start_q;
  byte_t            tx_data_q;

  assign last_byte = (byte_cnt == CNT_W'(THUMB_BYTES));
  assign issue     = (state == LOAD) && !abort;

  // ====================
  // Next state
  // ====================

  always_comb begin
    state_next = state;
    if (abort) begin
      state_next = IDLE;
    end else begin
      case (state)
        // An aborted frame still on the line blocks a new request
        IDLE: begin
          if (send_req && !tx_pending) begin
            state_next = FETCH;
          end
        end
        FETCH: state_next = LOAD;
        LOAD:  state_next = SEND;
        SEND: begin
          if (tx_done) begin
            state_next = last_byte ? IDLE : FETCH;
          end
        end
        default: state_next = IDLE;
      endcase
    end
  end

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state      <= IDLE;
      byte_cnt   <= '0;
      tx_start_q <= 1'b0;
      tx_pending <= 1'b0;
    end else begin
      state      <= state_next;
      tx_start_q <= issue;
      if (state == IDLE) begin
        byte_cnt <= '0;
      end else if (state == LOAD) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
      if (issue) begin
        tx_pending <= 1'b1;
      end else if (tx_done) begin
        tx_pending <= 1'b0;
      end
    end
  end

  // Buffer byte is valid during LOAD, one cycle after the read strobe
  always_ff @(posedge CLOCK_50) begin
    if (state == LOAD) begin
      tx_data_q <= thumb_data;
    end
  end

  assign thumb_rd = (state == FETCH);
  assign tx_req   = '{start: tx_start_q, data: tx_data_q};
  assign busy     = (state != IDLE);

  // Each read is followed by at least a load and a full frame
  a_rd_single: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0)
    thumb_rd |=> !thumb_rd
  );

endmodule

/* src/image_link.sv */
// Top level of the serial image control path
module image_link #(
  parameter int CLKS_PER_BIT = 434,
  parameter int THUMB_BYTES  = 1024
) (
  input  logic               CLOCK_50,
  input  logic               DLY_RST_0,
  input  logic               rx,
  input  logic               store_mode,
  input  logic               gray_mode,
  input  logic               send_req,
  input  logic               abort,
  input  link_pkg::byte_t    thumb_data,
  output logic               tx,
  output link_pkg::addr_t    frame_base,
  output logic               display_restart,
  output link_pkg::rx_beat_t store_beat,
  output logic               thumb_rd,
  output logic               busy
);
  import link_pkg::*;

  rx_beat_t rx_beat;
  tx_req_t  tx_req;
  logic     tx_done;

  // ====================
  // Command path
  // ====================

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rx        (rx),
    .rx_beat   (rx_beat)
  );

  image_select u_select (
    .CLOCK_50        (CLOCK_50),
    .DLY_RST_0       (DLY_RST_0),
    .rx_beat         (rx_beat),
    .store_mode      (store_mode),
    .gray_mode       (gray_mode),
    .frame_base      (frame_base),
    .store_beat      (store_beat),
    .display_restart (display_restart)
  );

  // ====================
  // Thumbnail path
  // ====================

  send_fsm #(
    .THUMB_BYTES (THUMB_BYTES)
  ) u_send (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .send_req   (send_req),
    .abort      (abort),
    .thumb_data (thumb_data),
    .thumb_rd   (thumb_rd),
    .tx_req     (tx_req),
    .tx_done    (tx_done),
    .busy       (busy)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .tx_req    (tx_req),
    .tx        (tx),
    .tx_done   (tx_done)
  );

endmodule

/* sim/tb_image_link.sv */
// Clock, reset, UART driver and monitor, buffer model, assertions and scoreboard
module tb_image_link;
  import link_pkg::*;

  localparam int CLKS_PER_BIT = 8;
  localparam int THUMB_BYTES  = 6;
  localparam int GAP_CLKS     = 2 * CLKS_PER_BIT;
  localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
  // Four index bytes, two in gray mode, three stored, two sends, abort tail
  localparam int TEST_FRAMES  = 4 + 2 + 3 + 2 * THUMB_BYTES + 2;
  localparam int LIMIT        = 2 * TEST_FRAMES * (FRAME_CLKS + GAP_CLKS);
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic     CLOCK_50;
  logic     DLY_RST_0;
  logic     rx;
  logic     store_mode;
  logic     gray_mode;
  logic     send_req;
  logic     abort;
  byte_t    thumb_data;
  logic     tx;
  addr_t    frame_base;
  logic     display_restart;
  rx_beat_t store_beat;
  logic     thumb_rd;
  logic     busy;

  string       test_name = "reset";
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          restart_count = 0;
  int          rd_count = 0;
  int          sent_at_abort;
  logic        frozen = 1'b0;
  logic        aborted = 1'b0;
  logic [31:0] lfsr = 32'h4d0f_3318;
  img_idx_t    exp_idx = '0;
  logic        exp_gray = 1'b0;
  int          exp_restarts = 0;
  byte_t       buf_byte;
  byte_t       mon_byte;
  byte_t       tx_q[$];
  byte_t       exp_q[$];
  byte_t       store_q[$];

  image_link #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .THUMB_BYTES  (THUMB_BYTES)
  ) DUT (
    .CLOCK_50        (CLOCK_50),
    .DLY_RST_0       (DLY_RST_0),
    .rx              (rx),
    .store_mode      (store_mode),
    .gray_mode       (gray_mode),
    .send_req        (send_req),
    .abort           (abort),
    .thumb_data      (thumb_data),
    .tx              (tx),
    .frame_base      (frame_base),
    .display_restart (display_restart),
    .store_beat      (store_beat),
    .thumb_rd        (thumb_rd),
    .busy            (busy)
  );

  initial begin
    CLOCK_50 = 1'b0;
    forever #20 CLOCK_50 = ~CLOCK_50;
  end

  // ====================
  // Helpers
  // ====================

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge CLOCK_50);
      #2;
    end
  endtask

  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  // One random byte with one LFSR step per bit
  task automatic next_byte(output byte_t b);
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
  endtask

  function automatic addr_t expected_base();
    addr_t base;
    if (exp_gray) begin
      return LIVE_BASE;
    end
    // Stored frames sit back to back from the first image
    base = IMAGE_BASE;
    for (int i = 0; i < exp_idx; i++) begin
      base = base + FRAME_WORDS;
    end
    return base;
  endfunction

  // 8N1 frame on rx followed by an idle gap
  task automatic send_frame(input byte_t b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx = bits[i];
      wait_cycles(CLKS_PER_BIT);
    end
    wait_cycles(GAP_CLKS);
  endtask

  task automatic send_command(input byte_t b);
    send_frame(b);
    if (!store_mode) begin
      if (b != exp_idx) begin
        exp_restarts++;
      end
      exp_idx = b;
    end
    expect_eq("frame_base", expected_base(), frame_base);
    expect_eq("restarts", exp_restarts, restart_count);
  endtask

  task automatic set_gray(input logic v);
    gray_mode = v;
    exp_gray  = v;
    exp_restarts++;
    wait_cycles(4);
    expect_eq("frame_base", expected_base(), frame_base);
    expect_eq("restarts", exp_restarts, restart_count);
  endtask

  task automatic pulse_send;
    send_req = 1'b1;
    wait_cycles(1);
    send_req = 1'b0;
  endtask

  // ====================
  // Monitors and models
  // ====================

  always @(posedge CLOCK_50) begin
    if (DLY_RST_0 && display_restart) begin
      restart_count++;
    end
    if (DLY_RST_0 && store_beat.valid) begin
      store_q.push_back(store_beat.data);
    end
  end

  // Buffer answers one cycle after each read strobe
  always @(posedge CLOCK_50) begin
    if (DLY_RST_0 && thumb_rd) begin
      #2;
      next_byte(buf_byte);
      thumb_data = buf_byte;
      exp_q.push_back(buf_byte);
      rd_count++;
    end
  end

  // Decodes tx near mid-bit on the falling edge
  always begin
    @(negedge CLOCK_50);
    if (DLY_RST_0 && !tx) begin
      repeat (CLKS_PER_BIT / 2) @(negedge CLOCK_50);
      if (tx) begin
        errors++;
        $display("%s: start bit on tx was shorter than half a bit", test_name);
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
        mon_byte[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
      if (!tx) begin
        errors++;
        $display("%s: stop bit on tx was low", test_name);
      end
      tx_q.push_back(mon_byte);
    end
  end

  always @(posedge CLOCK_50) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: the run did not end within %0d cycles in %s", LIMIT, test_name);
      $display("Finished with errors");
      $finish;
    end
  end

  // ====================
  // Assertions
  // ====================

  a_restart_pulse: assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    display_restart |=> !display_restart)
    else begin
      errors++;
      $display("CHECK FAILED %s restart width: expected 0, actual 1", test_name);
    end

  a_gray_live: assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    gray_mode && $past(gray_mode) |-> frame_base == LIVE_BASE)
    else begin
      errors++;
      $display("CHECK FAILED %s gray base: expected %0h, actual %0h",
               test_name, LIVE_BASE, frame_base);
    end

  a_store_frozen: assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    frozen |-> $stable(frame_base) && !display_restart)
    else begin
      errors++;
      $display("CHECK FAILED %s store base: expected %0h, actual %0h restart %0b",
               test_name, expected_base(), frame_base, display_restart);
    end

  a_idle_no_read: assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    !busy |-> !thumb_rd)
    else begin
      errors++;
      $display("CHECK FAILED %s idle read: expected 0, actual 1", test_name);
    end

  a_abort_idle: assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    abort |=> !busy)
    else begin
      errors++;
      $display("CHECK FAILED %s busy after abort: expected 0, actual 1", test_name);
    end

  a_no_read_after_abort: assert property (@(posedge CLOCK_50) disable iff (!DLY_RST_0)
    aborted |-> !thumb_rd)
    else begin
      errors++;
      $display("CHECK FAILED %s read after abort: expected 0, actual 1", test_name);
    end

  // ====================
  // Tests
  // ====================

  initial begin
    DLY_RST_0  = 1'b0;
    rx         = 1'b1;
    store_mode = 1'b0;
    gray_mode  = 1'b0;
    send_req   = 1'b0;
    abort      = 1'b0;
    thumb_data = '0;
    wait_cycles(2);
    DLY_RST_0 = 1'b1;
    wait_cycles(2);
    expect_eq("reset base", IMAGE_BASE, frame_base);

    test_name = "image index";
    send_command(8'h03);
    send_command(8'h03);
    send_command(8'h1a);
    send_command(8'h01);

    test_name = "gray mode";
    set_gray(1'b1);
    send_command(8'h05);
    send_command(8'h07);
    set_gray(1'b0);

    test_name = "store";
    store_mode = 1'b1;
    wait_cycles(2);
    frozen = 1'b1;
    send_command(8'h44);
    send_command(8'h0c);
    send_command(8'h99);
    frozen = 1'b0;
    store_mode = 1'b0;
    expect_eq("store beats", 3, store_q.size());
    if (store_q.size() == 3) begin
      expect_eq("store byte 0", 8'h44, store_q[0]);
      expect_eq("store byte 1", 8'h0c, store_q[1]);
      expect_eq("store byte 2", 8'h99, store_q[2]);
    end

    test_name = "thumbnail send";
    tx_q.delete();
    exp_q.delete();
    rd_count = 0;
    pulse_send();
    while (rd_count < 2) wait_cycles(1);
    pulse_send();
    while (busy) wait_cycles(1);
    // A request taken while busy would start a new send here
    wait_cycles(4);
    expect_eq("busy after last frame", 0, busy);
    expect_eq("reads", THUMB_BYTES, rd_count);
    expect_eq("frames", THUMB_BYTES, tx_q.size());
    for (int i = 0; i < tx_q.size() && i < exp_q.size(); i++) begin
      expect_eq($sformatf("byte %0d", i), exp_q[i], tx_q[i]);
    end

    test_name = "abort";
    tx_q.delete();
    exp_q.delete();
    rd_count = 0;
    pulse_send();
    while (rd_count < 2) wait_cycles(1);
    wait_cycles(20);
    abort = 1'b1;
    sent_at_abort = tx_q.size();
    wait_cycles(1);
    abort   = 1'b0;
    aborted = 1'b1;
    wait_cycles(2 * FRAME_CLKS);
    aborted = 1'b0;
    expect_eq("reads", 2, rd_count);
    checks++;
    assert (tx_q.size() <= sent_at_abort + 1) else begin
      errors++;
      $display("CHECK FAILED %s frames: expected at most %0d, actual %0d",
               test_name, sent_at_abort + 1, tx_q.size());
    end
    for (int i = 0; i < tx_q.size() && i < exp_q.size(); i++) begin
      expect_eq($sformatf("byte %0d", i), exp_q[i], tx_q[i]);
    end

    $display("Checks: %0d  Errors: %0d  Cycles: %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/link_pkg.sv
src/baud_timer.sv
src/uart_rx.sv
src/uart_tx.sv
src/image_select.sv
src/send_fsm.sv
src/image_link.sv
sim/tb_image_link.sv

/* Bender.yml */
package:
  name: image_link

sources:
  - src/link_pkg.sv
  - src/baud_timer.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/image_select.sv
  - src/send_fsm.sv
  - src/image_link.sv
  - target: simulation
    files:
      - sim/tb_image_link.sv
